//--- include/axi_ic_config.svh
`ifndef AXI_IC_CONFIG_SVH
`define AXI_IC_CONFIG_SVH

// Bus widths
`define AXI_IC_ADDR_W 32
`define AXI_IC_DATA_W 32
`define AXI_IC_ID_W   4
`define AXI_IC_LEN_W  8

// Register block windows, everything else maps to DRAM
`define AXI_IC_SA_BASE     32'hF000_0000
`define AXI_IC_SA_LAST     32'hF000_0005
`define AXI_IC_CORDIC_BASE 32'hF000_0006
`define AXI_IC_CORDIC_LAST 32'hF000_0009

`endif

//--- design/axi_ic_pkg.sv
`include "axi_ic_config.svh"

package axi_ic_pkg;

    typedef logic [`AXI_IC_ADDR_W-1:0] addr_t;
    typedef logic [`AXI_IC_DATA_W-1:0] data_t;
    typedef logic [`AXI_IC_ID_W-1:0]   id_t;
    typedef logic [`AXI_IC_LEN_W-1:0]  len_t;

    // AXI read response codes
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    // Decoded destination of a CPU read
    typedef enum logic [1:0] {
        TGT_DRAM   = 2'b00,
        TGT_SA     = 2'b01,
        TGT_CORDIC = 2'b10
    } target_e;

    typedef enum logic {
        RT_IDLE      = 1'b0,
        RT_WAIT_DATA = 1'b1
    } router_state_e;

endpackage

//--- design/axi_read_if.sv
`timescale 1ns/1ps

interface axi_read_if;
    import axi_ic_pkg::*;

    // Read address channel
    id_t   arid;
    addr_t araddr;
    len_t  arlen;
    logic  arvalid;
    logic  arready;

    // Read data channel
    id_t   rid;
    data_t rdata;
    resp_e rresp;
    logic  rlast;
    logic  rvalid;
    logic  rready;

    modport manager (
        output arid, araddr, arlen, arvalid,
        input  arready,
        input  rid, rdata, rresp, rlast, rvalid,
        output rready
    );

    modport subordinate (
        input  arid, araddr, arlen, arvalid,
        output arready,
        output rid, rdata, rresp, rlast, rvalid,
        input  rready
    );

endinterface

//--- design/axi_lite_read_if.sv
`timescale 1ns/1ps

interface axi_lite_read_if;
    import axi_ic_pkg::*;

    addr_t araddr;
    logic  arvalid;
    logic  arready;

    data_t rdata;
    resp_e rresp;
    logic  rvalid;
    logic  rready;

    modport manager (
        output araddr, arvalid,
        input  arready,
        input  rdata, rresp, rvalid,
        output rready
    );

    modport subordinate (
        input  araddr, arvalid,
        output arready,
        output rdata, rresp, rvalid,
        input  rready
    );

endinterface

//--- design/cpu_read_router.sv
`timescale 1ns/1ps
`include "axi_ic_config.svh"

module cpu_read_router (
    input logic                  ACLK,
    input logic                  ARESETN,
    axi_read_if.subordinate      cpu,
    axi_read_if.manager          dram,
    axi_lite_read_if.manager     sa,
    axi_lite_read_if.manager     cordic
);
    import axi_ic_pkg::*;

    router_state_e state_q;
    target_e       dec_tgt;
    target_e       tgt_q;
    id_t           id_q;
    logic          idle;
    logic          ar_hs;
    logic          r_last_hs;

    // Anything outside the register windows decodes to DRAM
    always_comb begin
        if (cpu.araddr >= `AXI_IC_SA_BASE && cpu.araddr <= `AXI_IC_SA_LAST) begin
            dec_tgt = TGT_SA;
        end else if (cpu.araddr >= `AXI_IC_CORDIC_BASE &&
                     cpu.araddr <= `AXI_IC_CORDIC_LAST) begin
            dec_tgt = TGT_CORDIC;
        end else begin
            dec_tgt = TGT_DRAM;
        end
    end

    assign idle = (state_q == RT_IDLE);

    // Only the decoded target sees the request
    assign sa.arvalid     = idle && cpu.arvalid && (dec_tgt == TGT_SA);
    assign cordic.arvalid = idle && cpu.arvalid && (dec_tgt == TGT_CORDIC);
    assign dram.arvalid   = idle && cpu.arvalid && (dec_tgt == TGT_DRAM);
    assign sa.araddr      = cpu.araddr;
    assign cordic.araddr  = cpu.araddr;
    assign dram.araddr    = cpu.araddr;
    assign dram.arid      = cpu.arid;
    assign dram.arlen     = cpu.arlen;

    always_comb begin
        case (dec_tgt)
            TGT_SA:     cpu.arready = idle && sa.arready;
            TGT_CORDIC: cpu.arready = idle && cordic.arready;
            default:    cpu.arready = idle && dram.arready;
        endcase
    end

    assign ar_hs = cpu.arvalid && cpu.arready;

    // R channel steered by the target latched at the AR handshake
    always_comb begin
        case (tgt_q)
            TGT_SA: begin
                cpu.rid    = id_q;
                cpu.rdata  = sa.rdata;
                cpu.rresp  = sa.rresp;
                cpu.rlast  = 1'b1;
                cpu.rvalid = !idle && sa.rvalid;
            end
            TGT_CORDIC: begin
                cpu.rid    = id_q;
                cpu.rdata  = cordic.rdata;
                cpu.rresp  = cordic.rresp;
                cpu.rlast  = 1'b1;
                cpu.rvalid = !idle && cordic.rvalid;
            end
            default: begin
                cpu.rid    = dram.rid;
                cpu.rdata  = dram.rdata;
                cpu.rresp  = dram.rresp;
                cpu.rlast  = dram.rlast;
                cpu.rvalid = !idle && dram.rvalid;
            end
        endcase
    end

    assign sa.rready     = !idle && (tgt_q == TGT_SA) && cpu.rready;
    assign cordic.rready = !idle && (tgt_q == TGT_CORDIC) && cpu.rready;
    assign dram.rready   = !idle && (tgt_q == TGT_DRAM) && cpu.rready;

    assign r_last_hs = cpu.rvalid && cpu.rready && cpu.rlast;

    always_ff @(posedge ACLK or negedge ARESETN) begin
        if (!ARESETN) begin
            state_q <= RT_IDLE;
            tgt_q   <= TGT_DRAM;
        end else begin
            case (state_q)
                RT_IDLE: begin
                    if (ar_hs) begin
                        state_q <= RT_WAIT_DATA;
                        tgt_q   <= dec_tgt;
                    end
                end
                RT_WAIT_DATA: begin
                    if (r_last_hs) begin
                        state_q <= RT_IDLE;
                    end
                end
                default: state_q <= RT_IDLE;
            endcase
        end
    end

    // Lite targets carry no ID so the request's ID is held for the response
    always_ff @(posedge ACLK) begin
        if (ar_hs) begin
            id_q <= cpu.arid;
        end
    end

    a_one_target: assert property (@(posedge ACLK) disable iff (!ARESETN)
        $onehot0({sa.arvalid, cordic.arvalid, dram.arvalid}))
        else $error("More than one target arvalid high");

    a_no_resp_idle: assert property (@(posedge ACLK) disable iff (!ARESETN)
        idle |-> !sa.rvalid && !cordic.rvalid && !dram.rvalid)
        else $error("Target rvalid high with no read outstanding");

    a_cpu_ar_hold: assert property (@(posedge ACLK) disable iff (!ARESETN)
        cpu.arvalid && !cpu.arready |=> cpu.arvalid)
        else $error("CPU arvalid dropped before its handshake");

endmodule

//--- design/dram_read_arbiter.sv
`timescale 1ns/1ps

module dram_read_arbiter (
    input logic              ACLK,
    input logic              ARESETN,
    axi_read_if.subordinate  cpu,
    axi_read_if.subordinate  acc,
    axi_read_if.manager      dram
);

    localparam logic OWN_CPU = 1'b0;
    localparam logic OWN_ACC = 1'b1;

    logic busy_q;
    logic owner_q;
    logic last_q;
    logic grant_idle;
    logic grant;
    logic ar_hs;
    logic r_last_hs;

    // Lone requester wins, on contention the one not served last
    always_comb begin
        if (cpu.arvalid && acc.arvalid) begin
            grant_idle = ~last_q;
        end else if (acc.arvalid) begin
            grant_idle = OWN_ACC;
        end else begin
            grant_idle = OWN_CPU;
        end
    end

    // Grant is frozen for the whole burst
    assign grant = busy_q ? owner_q : grant_idle;

    // AR mux
    assign dram.arvalid = !busy_q && ((grant == OWN_ACC) ? acc.arvalid : cpu.arvalid);
    assign dram.arid    = (grant == OWN_ACC) ? acc.arid   : cpu.arid;
    assign dram.araddr  = (grant == OWN_ACC) ? acc.araddr : cpu.araddr;
    assign dram.arlen   = (grant == OWN_ACC) ? acc.arlen  : cpu.arlen;

    assign cpu.arready = !busy_q && (grant == OWN_CPU) && dram.arready;
    assign acc.arready = !busy_q && (grant == OWN_ACC) && dram.arready;

    // R beats go only to the owner
    assign cpu.rid    = dram.rid;
    assign cpu.rdata  = dram.rdata;
    assign cpu.rresp  = dram.rresp;
    assign cpu.rlast  = dram.rlast;
    assign cpu.rvalid = busy_q && (owner_q == OWN_CPU) && dram.rvalid;

    assign acc.rid    = dram.rid;
    assign acc.rdata  = dram.rdata;
    assign acc.rresp  = dram.rresp;
    assign acc.rlast  = dram.rlast;
    assign acc.rvalid = busy_q && (owner_q == OWN_ACC) && dram.rvalid;

    assign dram.rready = busy_q && ((owner_q == OWN_ACC) ? acc.rready : cpu.rready);

    assign ar_hs     = dram.arvalid && dram.arready;
    assign r_last_hs = dram.rvalid && dram.rready && dram.rlast;

    always_ff @(posedge ACLK or negedge ARESETN) begin
        if (!ARESETN) begin
            busy_q  <= 1'b0;
            owner_q <= OWN_CPU;
            // CPU takes the first contended grant
            last_q  <= OWN_ACC;
        end else begin
            if (ar_hs) begin
                busy_q  <= 1'b1;
                owner_q <= grant;
                last_q  <= grant;
            end else if (r_last_hs) begin
                busy_q  <= 1'b0;
            end
        end
    end

    a_owner_stable: assert property (@(posedge ACLK) disable iff (!ARESETN)
        busy_q |=> $stable(owner_q))
        else $error("DRAM owner changed during a burst");

    a_no_rvalid_idle: assert property (@(posedge ACLK) disable iff (!ARESETN)
        !busy_q |-> !dram.rvalid)
        else $error("DRAM rvalid with no read outstanding");

    a_single_arready: assert property (@(posedge ACLK) disable iff (!ARESETN)
        !(cpu.arready && acc.arready))
        else $error("Both requesters see arready");

endmodule

//--- design/axi_read_interconnect.sv
`timescale 1ns/1ps

module axi_read_interconnect (
    input  logic               ACLK,
    input  logic               ARESETN,

    // CPU requester
    input  axi_ic_pkg::id_t    cpu_arid,
    input  axi_ic_pkg::addr_t  cpu_araddr,
    input  axi_ic_pkg::len_t   cpu_arlen,
    input  logic               cpu_arvalid,
    output logic               cpu_arready,
    output axi_ic_pkg::id_t    cpu_rid,
    output axi_ic_pkg::data_t  cpu_rdata,
    output axi_ic_pkg::resp_e  cpu_rresp,
    output logic               cpu_rlast,
    output logic               cpu_rvalid,
    input  logic               cpu_rready,

    // Accelerator requester, DRAM only
    input  axi_ic_pkg::id_t    acc_arid,
    input  axi_ic_pkg::addr_t  acc_araddr,
    input  axi_ic_pkg::len_t   acc_arlen,
    input  logic               acc_arvalid,
    output logic               acc_arready,
    output axi_ic_pkg::id_t    acc_rid,
    output axi_ic_pkg::data_t  acc_rdata,
    output axi_ic_pkg::resp_e  acc_rresp,
    output logic               acc_rlast,
    output logic               acc_rvalid,
    input  logic               acc_rready,

    // DRAM target
    output axi_ic_pkg::id_t    dram_arid,
    output axi_ic_pkg::addr_t  dram_araddr,
    output axi_ic_pkg::len_t   dram_arlen,
    output logic               dram_arvalid,
    input  logic               dram_arready,
    input  axi_ic_pkg::id_t    dram_rid,
    input  axi_ic_pkg::data_t  dram_rdata,
    input  axi_ic_pkg::resp_e  dram_rresp,
    input  logic               dram_rlast,
    input  logic               dram_rvalid,
    output logic               dram_rready,

    // Systolic array registers
    output axi_ic_pkg::addr_t  sa_araddr,
    output logic               sa_arvalid,
    input  logic               sa_arready,
    input  axi_ic_pkg::data_t  sa_rdata,
    input  axi_ic_pkg::resp_e  sa_rresp,
    input  logic               sa_rvalid,
    output logic               sa_rready,

    // CORDIC registers
    output axi_ic_pkg::addr_t  cordic_araddr,
    output logic               cordic_arvalid,
    input  logic               cordic_arready,
    input  axi_ic_pkg::data_t  cordic_rdata,
    input  axi_ic_pkg::resp_e  cordic_rresp,
    input  logic               cordic_rvalid,
    output logic               cordic_rready
);

    axi_read_if      cpu ();
    axi_read_if      acc ();
    axi_read_if      cpu_dram ();
    axi_read_if      dram ();
    axi_lite_read_if sa ();
    axi_lite_read_if cordic ();

    assign cpu.arid     = cpu_arid;
    assign cpu.araddr   = cpu_araddr;
    assign cpu.arlen    = cpu_arlen;
    assign cpu.arvalid  = cpu_arvalid;
    assign cpu_arready  = cpu.arready;
    assign cpu_rid      = cpu.rid;
    assign cpu_rdata    = cpu.rdata;
    assign cpu_rresp    = cpu.rresp;
    assign cpu_rlast    = cpu.rlast;
    assign cpu_rvalid   = cpu.rvalid;
    assign cpu.rready   = cpu_rready;

    assign acc.arid     = acc_arid;
    assign acc.araddr   = acc_araddr;
    assign acc.arlen    = acc_arlen;
    assign acc.arvalid  = acc_arvalid;
    assign acc_arready  = acc.arready;
    assign acc_rid      = acc.rid;
    assign acc_rdata    = acc.rdata;
    assign acc_rresp    = acc.rresp;
    assign acc_rlast    = acc.rlast;
    assign acc_rvalid   = acc.rvalid;
    assign acc.rready   = acc_rready;

    assign dram_arid    = dram.arid;
    assign dram_araddr  = dram.araddr;
    assign dram_arlen   = dram.arlen;
    assign dram_arvalid = dram.arvalid;
    assign dram.arready = dram_arready;
    assign dram.rid     = dram_rid;
    assign dram.rdata   = dram_rdata;
    assign dram.rresp   = dram_rresp;
    assign dram.rlast   = dram_rlast;
    assign dram.rvalid  = dram_rvalid;
    assign dram_rready  = dram.rready;

    assign sa_araddr    = sa.araddr;
    assign sa_arvalid   = sa.arvalid;
    assign sa.arready   = sa_arready;
    assign sa.rdata     = sa_rdata;
    assign sa.rresp     = sa_rresp;
    assign sa.rvalid    = sa_rvalid;
    assign sa_rready    = sa.rready;

    assign cordic_araddr  = cordic.araddr;
    assign cordic_arvalid = cordic.arvalid;
    assign cordic.arready = cordic_arready;
    assign cordic.rdata   = cordic_rdata;
    assign cordic.rresp   = cordic_rresp;
    assign cordic.rvalid  = cordic_rvalid;
    assign cordic_rready  = cordic.rready;

    cpu_read_router i_cpu_read_router (
        .ACLK    (ACLK),
        .ARESETN (ARESETN),
        .cpu     (cpu.subordinate),
        .dram    (cpu_dram.manager),
        .sa      (sa.manager),
        .cordic  (cordic.manager)
    );

    // CPU DRAM traffic shares the DRAM port with the accelerator
    dram_read_arbiter i_dram_read_arbiter (
        .ACLK    (ACLK),
        .ARESETN (ARESETN),
        .cpu     (cpu_dram.subordinate),
        .acc     (acc.subordinate),
        .dram    (dram.manager)
    );

endmodule

//--- dv/tb_axi_read_interconnect.sv
`timescale 1ns/1ps
`include "axi_ic_config.svh"

module tb_axi_read_interconnect;
    import axi_ic_pkg::*;

    localparam int N_READS     = 40;
    localparam int WATCHDOG_NS = 2 * N_READS * 8 * 10 * 100;

    logic    ACLK;
    logic    ARESETN;
    id_t     cpu_arid, cpu_rid, acc_arid, acc_rid, dram_arid, dram_rid;
    addr_t   cpu_araddr, acc_araddr, dram_araddr, sa_araddr, cordic_araddr;
    len_t    cpu_arlen, acc_arlen, dram_arlen;
    data_t   cpu_rdata, acc_rdata, dram_rdata, sa_rdata, cordic_rdata;
    resp_e   cpu_rresp, acc_rresp, dram_rresp, sa_rresp, cordic_rresp;
    logic    cpu_arvalid, cpu_arready, cpu_rlast, cpu_rvalid, cpu_rready;
    logic    acc_arvalid, acc_arready, acc_rlast, acc_rvalid, acc_rready;
    logic    dram_arvalid, dram_arready, dram_rlast, dram_rvalid, dram_rready;
    logic    sa_arvalid, sa_arready, sa_rvalid, sa_rready;
    logic    cordic_arvalid, cordic_arready, cordic_rvalid, cordic_rready;

    int      errors;
    int      contended;
    int      exp_sa, exp_cordic, exp_dram;
    int      got_sa, got_cordic, got_dram;
    logic    last_served;
    logic [1:0] outstanding;

    axi_read_interconnect i_dut (.*);

    initial ACLK = 1'b0;
    always #50 ACLK = ~ACLK;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h actual %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // Memory map as seen by the CPU port
    function automatic target_e decode_target(input addr_t addr);
        if (addr >= `AXI_IC_SA_BASE && addr <= `AXI_IC_SA_LAST)
            return TGT_SA;
        if (addr >= `AXI_IC_CORDIC_BASE && addr <= `AXI_IC_CORDIC_LAST)
            return TGT_CORDIC;
        return TGT_DRAM;
    endfunction

    function automatic data_t expect_data(input target_e tgt, input addr_t addr, input int k);
        case (tgt)
            TGT_SA:     return addr ^ 32'hA5A5_A5A5;
            TGT_CORDIC: return addr ^ 32'hC0C0_C0C0;
            default:    return addr + k;
        endcase
    endfunction

    // Boundaries, register windows and plain DRAM addresses
    function automatic addr_t pick_addr(input int port);
        int unsigned sel;
        if (port == 1)
            return $urandom_range(32'hEFFF_FFFF);
        sel = $urandom_range(9);
        case (sel)
            0:       return `AXI_IC_SA_BASE;
            1:       return `AXI_IC_SA_LAST;
            2:       return `AXI_IC_CORDIC_BASE;
            3:       return `AXI_IC_CORDIC_LAST;
            4:       return `AXI_IC_CORDIC_LAST + 1;
            5:       return `AXI_IC_CORDIC_LAST + 1 + $urandom_range(15);
            6:       return `AXI_IC_SA_BASE + $urandom_range(`AXI_IC_SA_LAST - `AXI_IC_SA_BASE);
            7:       return `AXI_IC_CORDIC_BASE + $urandom_range(3);
            default: return $urandom;
        endcase
    endfunction

    task automatic drive_ar(input int port, input logic valid, input id_t id,
                            input addr_t addr, input len_t len);
        if (port == 0) begin
            cpu_arvalid = valid;
            cpu_arid    = id;
            cpu_araddr  = addr;
            cpu_arlen   = len;
        end else begin
            acc_arvalid = valid;
            acc_arid    = id;
            acc_araddr  = addr;
            acc_arlen   = len;
        end
    endtask

    task automatic drive_rready(input int port, input logic ready);
        if (port == 0)
            cpu_rready = ready;
        else
            acc_rready = ready;
    endtask

    task automatic check_outputs_idle();
        check_value("dram_arvalid", 0, dram_arvalid);
        check_value("sa_arvalid", 0, sa_arvalid);
        check_value("cordic_arvalid", 0, cordic_arvalid);
        check_value("cpu_rvalid", 0, cpu_rvalid);
        check_value("acc_rvalid", 0, acc_rvalid);
    endtask

    // One read at a time per requester with every beat checked on its handshake
    task automatic issue_reads(input int port, input int count);
        addr_t   addr;
        len_t    len;
        id_t     id;
        target_e tgt;
        int      beats;
        int      k;
        string   who;
        id_t     r_id;
        data_t   r_data;
        logic [1:0] r_resp;
        logic    r_last;
        who = (port == 0) ? "cpu" : "acc";
        for (int n = 0; n < count; n++) begin
            @(negedge ACLK);
            addr = pick_addr(port);
            tgt  = (port == 0) ? decode_target(addr) : TGT_DRAM;
            len  = (tgt == TGT_DRAM) ? len_t'($urandom_range(7)) : '0;
            id   = id_t'($urandom);
            drive_ar(port, 1'b1, id, addr, len);
            @(posedge ACLK);
            while (!((port == 0) ? cpu_arready : acc_arready))
                @(posedge ACLK);
            outstanding[port] = 1'b1;
            case (tgt)
                TGT_SA:     exp_sa++;
                TGT_CORDIC: exp_cordic++;
                default:    exp_dram++;
            endcase
            @(negedge ACLK);
            drive_ar(port, 1'b0, id, addr, len);
            beats = (tgt == TGT_DRAM) ? len + 1 : 1;
            k = 0;
            while (k < beats) begin
                drive_rready(port, $urandom_range(1));
                @(posedge ACLK);
                if ((port == 0) ? (cpu_rvalid && cpu_rready) : (acc_rvalid && acc_rready)) begin
                    r_id   = (port == 0) ? cpu_rid : acc_rid;
                    r_data = (port == 0) ? cpu_rdata : acc_rdata;
                    r_resp = (port == 0) ? cpu_rresp : acc_rresp;
                    r_last = (port == 0) ? cpu_rlast : acc_rlast;
                    check_value({who, "_rid"}, id, r_id);
                    check_value({who, "_rdata"}, expect_data(tgt, addr, k), r_data);
                    check_value({who, "_rresp"},
                                (tgt == TGT_DRAM && addr[3:2] == 2'b11) ? SLVERR : OKAY, r_resp);
                    check_value({who, "_rlast"}, k == beats - 1, r_last);
                    k++;
                end
                @(negedge ACLK);
            end
            outstanding[port] = 1'b0;
            drive_rready(port, 1'b0);
        end
    endtask

    // SA and CORDIC are only reached from the CPU, so one model serves both
    always begin : lite_model
        logic  is_sa;
        addr_t addr;
        @(posedge ACLK);
        if (ARESETN && (sa_arvalid || cordic_arvalid)) begin
            is_sa = sa_arvalid;
            repeat ($urandom_range(3)) @(posedge ACLK);
            @(negedge ACLK);
            sa_arready     = is_sa;
            cordic_arready = !is_sa;
            @(posedge ACLK);
            addr = is_sa ? sa_araddr : cordic_araddr;
            @(negedge ACLK);
            sa_arready     = 1'b0;
            cordic_arready = 1'b0;
            if (is_sa) begin
                got_sa++;
                sa_rvalid = 1'b1;
                sa_rdata  = addr ^ 32'hA5A5_A5A5;
                sa_rresp  = OKAY;
            end else begin
                got_cordic++;
                cordic_rvalid = 1'b1;
                cordic_rdata  = addr ^ 32'hC0C0_C0C0;
                cordic_rresp  = OKAY;
            end
            @(posedge ACLK);
            while (!(is_sa ? sa_rready : cordic_rready))
                @(posedge ACLK);
            @(negedge ACLK);
            sa_rvalid     = 1'b0;
            cordic_rvalid = 1'b0;
        end
    end

    // DRAM burst responder with random accept delay and beat gaps
    always begin : dram_model
        id_t   id;
        addr_t addr;
        len_t  len;
        @(posedge ACLK);
        if (ARESETN && dram_arvalid) begin
            repeat ($urandom_range(3)) @(posedge ACLK);
            @(negedge ACLK);
            dram_arready = 1'b1;
            @(posedge ACLK);
            id   = dram_arid;
            addr = dram_araddr;
            len  = dram_arlen;
            got_dram++;
            @(negedge ACLK);
            dram_arready = 1'b0;
            for (int k = 0; k <= len; k++) begin
                repeat ($urandom_range(2)) @(negedge ACLK);
                dram_rvalid = 1'b1;
                dram_rid    = id;
                dram_rdata  = addr + k;
                dram_rresp  = (addr[3:2] == 2'b11) ? SLVERR : OKAY;
                dram_rlast  = (k == len);
                @(posedge ACLK);
                while (!dram_rready)
                    @(posedge ACLK);
                @(negedge ACLK);
                dram_rvalid = 1'b0;
                dram_rlast  = 1'b0;
            end
        end
    end

    // Expected DRAM owner on every DRAM address handshake
    always @(posedge ACLK) begin : grant_monitor
        logic cpu_wants;
        logic winner;
        logic expected;
        if (ARESETN) begin
            cpu_wants = cpu_arvalid && (decode_target(cpu_araddr) == TGT_DRAM);
            if (dram_arvalid && dram_arready) begin
                winner = acc_arvalid && acc_arready;
                if (cpu_wants && acc_arvalid) begin
                    expected = ~last_served;
                    contended++;
                end else begin
                    expected = acc_arvalid;
                end
                check_value("dram grant owner", expected, winner);
                last_served = expected;
            end
            if (cpu_rvalid && !outstanding[0])
                report_error("CPU port saw rvalid with no read outstanding");
            if (acc_rvalid && !outstanding[1])
                report_error("Accelerator port saw rvalid with no read outstanding");
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog timeout at %0t, reads did not complete, %0d errors", $time, errors);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : main
        void'($urandom(17));
        errors      = 0;
        contended   = 0;
        exp_sa      = 0;
        exp_cordic  = 0;
        exp_dram    = 0;
        got_sa      = 0;
        got_cordic  = 0;
        got_dram    = 0;
        last_served = 1'b1;
        outstanding = 2'b00;
        ARESETN     = 1'b0;
        drive_ar(0, 1'b0, '0, '0, '0);
        drive_ar(1, 1'b0, '0, '0, '0);
        cpu_rready     = 1'b0;
        acc_rready     = 1'b0;
        dram_arready   = 1'b0;
        dram_rvalid    = 1'b0;
        dram_rid       = '0;
        dram_rdata     = '0;
        dram_rresp     = OKAY;
        dram_rlast     = 1'b0;
        sa_arready     = 1'b0;
        sa_rvalid      = 1'b0;
        sa_rdata       = '0;
        sa_rresp       = OKAY;
        cordic_arready = 1'b0;
        cordic_rvalid  = 1'b0;
        cordic_rdata   = '0;
        cordic_rresp   = OKAY;

        repeat (5) begin
            @(posedge ACLK);
            check_outputs_idle();
        end
        @(negedge ACLK);
        ARESETN = 1'b1;
        repeat (2) begin
            @(posedge ACLK);
            check_outputs_idle();
        end

        fork
            issue_reads(0, N_READS);
            issue_reads(1, N_READS);
        join
        repeat (4) @(posedge ACLK);

        // Each target saw exactly the reads the memory map sends it
        check_value("sa read count", exp_sa, got_sa);
        check_value("cordic read count", exp_cordic, got_cordic);
        check_value("dram read count", exp_dram, got_dram);
        if (contended == 0)
            report_error("Both requesters never competed for DRAM");

        $display("Run complete: %0d reads, %0d contended grants, %0d errors",
                 2 * N_READS, contended, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+include
design/axi_ic_pkg.sv
design/axi_read_if.sv
design/axi_lite_read_if.sv
design/cpu_read_router.sv
design/dram_read_arbiter.sv
design/axi_read_interconnect.sv
dv/tb_axi_read_interconnect.sv

//--- Bender.yml
package:
  name: axi_read_interconnect

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/axi_ic_pkg.sv
      - design/axi_read_if.sv
      - design/axi_lite_read_if.sv
      - design/cpu_read_router.sv
      - design/dram_read_arbiter.sv
      - design/axi_read_interconnect.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_axi_read_interconnect.sv
